// File: list.f
+incdir+common
common/npc_pkg.sv
verilog/MuxKey.sv
idu/Idu.sv
idu/ImmGen.sv
exu/RegFile.sv
exu/Exu.sv
verilog/Ifu.sv
verilog/NpcTop.sv
sim/ClockGen.sv
sim/npc_asserts.sv
sim/tb_npc.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = tb_npc
FILELIST = list.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/tb_npc.sv
`timescale 1ns/1ps
`include "npc_cfg.svh"

module tb_npc import npc_pkg::*; ();
    localparam int PROG_WORDS = 32;
    localparam int RST_LIMIT = 20;
    localparam int RUN_LIMIT = 64;
    localparam logic [31:0] NOP = 32'h00000013;
    localparam logic [31:0] HALT_PC = `RESET_PC + 32'd76;    // word 19

    logic        clk;
    logic        rst;
    logic [31:0] imemAddr;
    logic [31:0] imemData;
    logic        wbEn;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    logic        halt;

    logic [31:0] prog [PROG_WORDS];
    logic [31:0] rngState;
    logic [31:0] modelRegs [32];
    logic [31:0] modelPc;
    logic        modelHalt;
    logic        runPassed;
    logic        failReported;

    ClockGen clockGen0 (
        .clk(clk),
        .rst(rst)
    );

    NpcTop dut0 (
        .clk(clk),
        .rst(rst),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .wbEn(wbEn),
        .wbAddr(wbAddr),
        .wbData(wbData),
        .halt(halt)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, 3'b000, rd, op};
    endfunction

    function automatic logic [31:0] encodeJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
    endfunction

    function automatic logic [31:0] signExtI(input logic [31:0] instr);
        return {{20{instr[31]}}, instr[31:20]};
    endfunction

    function automatic logic [31:0] jumpOffset(input logic [31:0] instr);
        return {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    endfunction

    // out of range reads give a nop
    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - `RESET_PC;
        if ($isunknown(addr) || offset[31:7] != '0) begin
            return NOP;
        end
        return prog[offset[6:2]];
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        failReported = 1'b1;
        $display("Simulation FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
        failRun($sformatf("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    // one instruction of the reference model against the DUT
    task automatic stepModel();
        logic [31:0] instr;
        logic [6:0]  op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic        expEn;
        logic [31:0] expData;
        logic [31:0] nextPc;
        instr = fetchWord(modelPc);
        op = instr[6:0];
        rd = instr[11:7];
        rs1 = instr[19:15];
        expEn = 1'b1;
        expData = '0;
        nextPc = modelPc + 32'd4;
        if (op == opLui) begin
            expData = {instr[31:12], 12'b0};
        end else if (op == opAuipc) begin
            expData = modelPc + {instr[31:12], 12'b0};
        end else if (op == opJal) begin
            expData = modelPc + 32'd4;
            nextPc = modelPc + jumpOffset(instr);
        end else if (op == opJalr && instr[14:12] == 3'b000) begin
            expData = modelPc + 32'd4;
            nextPc = (modelRegs[rs1] + signExtI(instr)) & ~32'd1;
        end else if (op == opOpImm && instr[14:12] == 3'b000) begin
            expData = modelRegs[rs1] + signExtI(instr);
        end else if (op == opSystem) begin
            expEn = 1'b0;
            nextPc = modelPc;
            modelHalt = 1'b1;
        end else begin
            expEn = 1'b0;    // unknown opcode
        end
        assert (imemAddr === modelPc) else reportMismatch("imemAddr", imemAddr, modelPc);
        assert (halt === modelHalt) else reportMismatch("halt", 32'(halt), 32'(modelHalt));
        assert (wbEn === expEn) else reportMismatch("wbEn", 32'(wbEn), 32'(expEn));
        if (expEn) begin
            assert (wbAddr === rd) else reportMismatch("wbAddr", 32'(wbAddr), 32'(rd));
            assert (wbData === expData) else reportMismatch("wbData", wbData, expData);
            if (rd != 5'd0) begin
                modelRegs[rd] = expData;
            end
        end
        modelPc = nextPc;
    endtask

    always @(posedge clk) begin
        #1;
        imemData = fetchWord(imemAddr);
    end

    initial begin
        logic [4:0]  rd;
        logic [4:0]  prevRd;
        logic [11:0] imm12;
        int          waitCycles;
        imemData = '0;
        runPassed = 1'b0;
        failReported = 1'b0;
        rngState = 32'd48;
        prevRd = 5'd0;
        // addi chain where each one reads the previous rd
        for (int k = 0; k < 8; k++) begin
            rngState = xorshift32(rngState);
            rd = rngState[4:0];
            imm12 = rngState[19:8];
            if (k == 1) imm12[11] = 1'b1;
            if (k == 3) rd = 5'd0;    // next one reads x0
            prog[k] = encodeI(imm12, prevRd, rd, opOpImm);
            prevRd = rd;
        end
        prog[8] = {20'h12345, 5'd5, opLui};
        prog[9] = {20'h00010, 5'd6, opAuipc};
        prog[10] = encodeJ(21'd12, 5'd1);
        prog[11] = encodeI(12'h7ff, 5'd0, 5'd7, opOpImm);    // skipped
        prog[12] = encodeI(12'h7ff, 5'd0, 5'd7, opOpImm);
        prog[13] = {20'h80000, 5'd10, opLui};
        prog[14] = encodeI(12'h040, 5'd10, 5'd10, opOpImm);
        prog[15] = encodeI(12'd5, 5'd10, 5'd2, opJalr);     // odd target
        prog[16] = encodeI(12'h7ff, 5'd0, 5'd7, opOpImm);
        prog[17] = 32'h0000000b;
        prog[18] = encodeI(12'hffd, 5'd2, 5'd11, opOpImm);
        prog[19] = 32'h00100073;    // ebreak
        for (int k = 20; k < PROG_WORDS; k++) begin
            prog[k] = encodeI(12'd1, 5'd0, 5'd7, opOpImm);
        end
        for (int k = 0; k < 32; k++) begin
            modelRegs[k] = '0;
        end
        modelPc = `RESET_PC;
        modelHalt = 1'b0;

        waitCycles = 0;
        @(negedge clk);
        while (rst === 1'b1) begin
            assert (wbEn === 1'b0) else reportMismatch("wbEn in reset", 32'(wbEn), 32'd0);
            @(negedge clk);
            waitCycles++;
            if (waitCycles > RST_LIMIT) failRun("timeout: reset was never released");
        end

        waitCycles = 0;
        while (!modelHalt) begin
            stepModel();
            if (!modelHalt) begin
                @(negedge clk);
                waitCycles++;
                if (waitCycles > RUN_LIMIT) failRun("timeout: the core never reached ebreak");
            end
        end
        assert (modelPc === HALT_PC) else reportMismatch("halt pc", modelPc, HALT_PC);

        // stays halted
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            assert (imemAddr === HALT_PC) else reportMismatch("imemAddr", imemAddr, HALT_PC);
            assert (wbEn === 1'b0) else reportMismatch("wbEn", 32'(wbEn), 32'd0);
        end

        if (dut0.asserts0.failCount == 0) begin
            runPassed = 1'b1;
            $display("Simulation PASSED");
            $finish;
        end else begin
            failRun("a bound concurrent assertion failed");
        end
    end

    final begin
        if (!runPassed && !failReported) begin
            $display("Simulation FAILED");
        end
    end

endmodule

// File: sim/npc_asserts.sv
`timescale 1ns/1ps
`include "npc_cfg.svh"

module npc_asserts (
    input logic             clk,
    input logic             rst,
    input logic [`XLEN-1:0] imemAddr,
    input logic             wbEn,
    input logic             halt
);
    int failCount = 0;

    addrAligned: assert property (@(posedge clk) disable iff (rst) imemAddr[1:0] == 2'b00)
        else begin
            failCount++;
            $error("fetch address is not word aligned");
        end

    // first fetch after reset release
    firstFetch: assert property (@(posedge clk) $fell(rst) |-> imemAddr == `RESET_PC)
        else begin
            failCount++;
            $error("first fetch address after reset is not the reset PC");
        end

    haltHoldsPc: assert property (@(posedge clk) disable iff (rst)
        halt |=> halt && $stable(imemAddr))
        else begin
            failCount++;
            $error("fetch address moved after halt");
        end

    haltNoWrite: assert property (@(posedge clk) disable iff (rst) halt |=> !wbEn)
        else begin
            failCount++;
            $error("register write after halt");
        end

    noWriteInReset: assert property (@(posedge clk) rst |-> !wbEn)
        else begin
            failCount++;
            $error("register write during reset");
        end

endmodule

bind NpcTop npc_asserts asserts0 (
    .clk(clk),
    .rst(rst),
    .imemAddr(imemAddr),
    .wbEn(wbEn),
    .halt(halt)
);

// File: sim/ClockGen.sv
`timescale 1ns/1ps

module ClockGen #(
    parameter int HALF_PERIOD = 5,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;    // released just after the edge
    end

endmodule

// File: verilog/NpcTop.sv
`timescale 1ns/1ps
`include "npc_cfg.svh"

module NpcTop
    import npc_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    output logic [`XLEN-1:0] imemAddr,
    input  logic [`XLEN-1:0] imemData,
    output logic             wbEn,
    output logic [4:0]       wbAddr,
    output logic [`XLEN-1:0] wbData,
    output logic             halt
);
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] result;
    logic             regWr;
    aluOpT            aluOp;
    extOpT            extOp;
    aluASelT          aluASel;
    aluBSelT          aluBSel;
    branchT           branch;

    assign imemAddr = pc;

    // same enable goes to the register file
    assign wbEn = regWr & ~halt & ~rst;
    assign wbAddr = imemData[11:7];
    assign wbData = result;

    Ifu ifu0 (
        .clk(clk),
        .rst(rst),
        .branch(branch),
        .imm(imm),
        .rs1Data(rs1Data),
        .halt(halt),
        .pc(pc)
    );

    Idu idu0 (
        .instr(imemData),
        .regWr(regWr),
        .aluOp(aluOp),
        .extOp(extOp),
        .aluASel(aluASel),
        .aluBSel(aluBSel),
        .branch(branch),
        .halt(halt)
    );

    ImmGen immGen0 (
        .instr(imemData),
        .extOp(extOp),
        .imm(imm)
    );

    RegFile regFile0 (
        .clk(clk),
        .rst(rst),
        .rs1Addr(imemData[19:15]),
        .rs2Addr(imemData[24:20]),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .wrEn(wbEn),
        .wrAddr(wbAddr),
        .wrData(result)
    );

    Exu exu0 (
        .pc(pc),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .imm(imm),
        .aluASel(aluASel),
        .aluBSel(aluBSel),
        .aluOp(aluOp),
        .result(result)
    );

endmodule

// File: verilog/Ifu.sv
`timescale 1ns/1ps
`include "npc_cfg.svh"

module Ifu
    import npc_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  branchT           branch,
    input  logic [`XLEN-1:0] imm,
    input  logic [`XLEN-1:0] rs1Data,
    input  logic             halt,
    output logic [`XLEN-1:0] pc
);
    logic [`XLEN-1:0] nextPc;
    logic [`XLEN-1:0] jalrTarget;

    assign jalrTarget = rs1Data + imm;

    always_comb begin
        case (branch)
            brJal:   nextPc = pc + imm;
            brJalr:  nextPc = {jalrTarget[`XLEN-1:1], 1'b0};  // bit 0 cleared
            default: nextPc = pc + `XLEN'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (!halt) begin    // pc stays on ebreak
            pc <= nextPc;
        end
    end

endmodule

// File: exu/Exu.sv
`timescale 1ns/1ps
`include "npc_cfg.svh"

module Exu
    import npc_pkg::*;
(
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1Data,
    input  logic [`XLEN-1:0] rs2Data,
    input  logic [`XLEN-1:0] imm,
    input  aluASelT          aluASel,
    input  aluBSelT          aluBSel,
    input  aluOpT            aluOp,
    output logic [`XLEN-1:0] result
);
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;

    assign opA = (aluASel == selPc) ? pc : rs1Data;

    always_comb begin
        case (aluBSel)
            selRs2:  opB = rs2Data;
            selImm:  opB = imm;
            selFour: opB = `XLEN'd4;    // link address
            default: opB = rs2Data;
        endcase
    end

    always_comb begin
        case (aluOp)
            add:     result = opA + opB;
            sub:     result = opA - opB;
            passB:   result = opB;
            default: result = opA + opB;
        endcase
    end

endmodule

// File: exu/RegFile.sv
`timescale 1ns/1ps
`include "npc_cfg.svh"

module RegFile (
    input  logic             clk,
    input  logic             rst,
    input  logic [4:0]       rs1Addr,
    input  logic [4:0]       rs2Addr,
    output logic [`XLEN-1:0] rs1Data,
    output logic [`XLEN-1:0] rs2Data,
    input  logic             wrEn,
    input  logic [4:0]       wrAddr,
    input  logic [`XLEN-1:0] wrData
);
    logic [`XLEN-1:0] regs [`REG_NUM];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != 5'd0) begin    // x0 writes dropped
            regs[wrAddr] <= wrData;
        end
    end

    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

// File: idu/ImmGen.sv
`timescale 1ns/1ps
`include "npc_cfg.svh"

module ImmGen
    import npc_pkg::*;
(
    input  logic [`XLEN-1:0] instr,
    input  extOpT            extOp,
    output logic [`XLEN-1:0] imm
);
    logic sign;

    assign sign = instr[31];

    always_comb begin
        unique case (extOp)
            immI: imm = {{(`XLEN-12){sign}}, instr[31:20]};
            immU: imm = {instr[31:12], 12'b0};
            immS: imm = {{(`XLEN-12){sign}}, instr[31:25], instr[11:7]};
            immB: imm = {{(`XLEN-12){sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immJ: imm = {{(`XLEN-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

// File: idu/Idu.sv
`timescale 1ns/1ps
`include "npc_cfg.svh"

module Idu
    import npc_pkg::*;
(
    input  logic [31:0] instr,
    output logic        regWr,
    output aluOpT       aluOp,
    output extOpT       extOp,
    output aluASelT     aluASel,
    output aluBSelT     aluBSel,
    output branchT      branch,
    output logic        halt
);
    localparam int NR_INSTR = 5;

    // {opcode[6:2], funct3, 0}
    localparam logic [8:0] keyLui   = {opLui[6:2], 4'b0000};
    localparam logic [8:0] keyAuipc = {opAuipc[6:2], 4'b0000};
    localparam logic [8:0] keyJal   = {opJal[6:2], 4'b0000};
    localparam logic [8:0] keyJalr  = {opJalr[6:2], 3'b000, 1'b0};
    localparam logic [8:0] keyAddi  = {opOpImm[6:2], 3'b000, 1'b0};

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [3:0] functKey;
    logic [8:0] instrType;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // U and J formats carry immediate bits where funct3 would be
    assign functKey = (opcode == opJalr || opcode == opOpImm) ? {funct3, 1'b0} : 4'b0000;
    assign instrType = {opcode[6:2], functKey};

    assign halt = (opcode == opSystem);

    MuxKey #(.NR_KEY(NR_INSTR), .keyT(logic [8:0]), .dataT(logic)) regWrMux (
        .key(instrType),
        .lut({keyLui, 1'b1, keyAuipc, 1'b1, keyJal, 1'b1, keyJalr, 1'b1, keyAddi, 1'b1}),
        .defaultOut(1'b0),
        .out(regWr)
    );

    MuxKey #(.NR_KEY(NR_INSTR), .keyT(logic [8:0]), .dataT(aluOpT)) aluOpMux (
        .key(instrType),
        .lut({keyLui, passB, keyAuipc, add, keyJal, add, keyJalr, add, keyAddi, add}),
        .defaultOut(add),
        .out(aluOp)
    );

    MuxKey #(.NR_KEY(NR_INSTR), .keyT(logic [8:0]), .dataT(extOpT)) extOpMux (
        .key(instrType),
        .lut({keyLui, immU, keyAuipc, immU, keyJal, immJ, keyJalr, immI, keyAddi, immI}),
        .defaultOut(immI),
        .out(extOp)
    );

    // lui passes B so operand A does not matter
    MuxKey #(.NR_KEY(NR_INSTR), .keyT(logic [8:0]), .dataT(aluASelT)) aluASelMux (
        .key(instrType),
        .lut({keyLui, selRs1, keyAuipc, selPc, keyJal, selPc, keyJalr, selPc,
              keyAddi, selRs1}),
        .defaultOut(selRs1),
        .out(aluASel)
    );

    MuxKey #(.NR_KEY(NR_INSTR), .keyT(logic [8:0]), .dataT(aluBSelT)) aluBSelMux (
        .key(instrType),
        .lut({keyLui, selImm, keyAuipc, selImm, keyJal, selFour, keyJalr, selFour,
              keyAddi, selImm}),
        .defaultOut(selRs2),
        .out(aluBSel)
    );

    MuxKey #(.NR_KEY(NR_INSTR), .keyT(logic [8:0]), .dataT(branchT)) branchMux (
        .key(instrType),
        .lut({keyLui, brNone, keyAuipc, brNone, keyJal, brJal, keyJalr, brJalr,
              keyAddi, brNone}),
        .defaultOut(brNone),
        .out(branch)
    );

endmodule

// File: verilog/MuxKey.sv
`timescale 1ns/1ps
`include "npc_cfg.svh"

module MuxKey #(
    parameter int NR_KEY = 2,
    parameter type keyT = logic [8:0],
    parameter type dataT = logic
) (
    input  keyT  key,
    input  logic [NR_KEY-1:0][$bits(keyT)+$bits(dataT)-1:0] lut,
    input  dataT defaultOut,
    output dataT out
);
    localparam int KEY_W = $bits(keyT);
    localparam int DATA_W = $bits(dataT);
    localparam int PAIR_W = KEY_W + DATA_W;

    // each pair is {key, value} with a unique key
    always_comb begin
        out = defaultOut;
        for (int i = 0; i < NR_KEY; i++) begin
            if (keyT'(lut[i][PAIR_W-1 -: KEY_W]) == key) begin
                out = dataT'(lut[i][DATA_W-1:0]);
            end
        end
    end

endmodule

// File: common/npc_pkg.sv
package npc_pkg;

    // alu operation
    typedef enum logic [3:0] {
        add   = 4'b0000,
        sub   = 4'b1000,
        passB = 4'b0011    // lui
    } aluOpT;

    // immediate format
    typedef enum logic [2:0] {
        immI = 3'b000,
        immU = 3'b001,
        immS = 3'b010,
        immB = 3'b011,
        immJ = 3'b100
    } extOpT;

    typedef enum logic {
        selRs1 = 1'b0,
        selPc  = 1'b1
    } aluASelT;

    typedef enum logic [1:0] {
        selRs2  = 2'b00,
        selImm  = 2'b01,
        selFour = 2'b10
    } aluBSelT;

    // next pc kind
    typedef enum logic [2:0] {
        brNone = 3'b000,
        brJal  = 3'b001,
        brJalr = 3'b010
    } branchT;

    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opSystem = 7'b1110011;   // ebreak halts the core

endpackage

// File: common/npc_cfg.svh
`ifndef NPC_CFG_SVH
`define NPC_CFG_SVH

// data and address width
`define XLEN 32

`define REG_NUM 32

// first fetch after reset
`define RESET_PC 32'h80000000

`endif
